/* compile.f */
+incdir+.
cache_pkg.sv
line_fill_if.sv
cache_tag_store.sv
cache_line_store.sv
cache_miss_ctrl.sv
cache_top.sv
tb_clock.sv
cache_chk.sv
cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= cache_tb
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* cache_tb.sv */
/*
 * Testbench for cache_top with a burst RAM model, a shadow memory with
 * a reference read, directed and random requests, and data checks.
 */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_tb;
  import cache_pkg::*;

  // directed requests first, then the random mix
  localparam int    num_random  = 200;
  localparam int    num_ops     = 14 + num_random;
  localparam int    reset_len   = 16;
  localparam int    cycle_limit = 40 * num_ops + reset_len;
  localparam int    mem_bytes   = 2 ** `CACHE_ADDR_BITS;
  localparam addr_t first_addr  = 12'h120;

  logic   clk;
  logic   rst;
  addr_t  address;
  word_t  data_in;
  wmask_t write_enable;
  word_t  data_out;
  logic   data_out_ready;
  logic   busy;
  logic   br_cmd;
  logic   br_cmd_en;
  baddr_t br_addr;
  bword_t br_wr_data;
  bword_t br_rd_data;
  logic   br_rd_data_ready;

  bword_t     ram [mem_bytes / 8];
  logic [7:0] shadow [mem_bytes];
  logic [31:0] rng;
  int         cycles;
  int         evictions;
  int         rd_wait;
  int         rd_beat;
  int         wr_beat;
  baddr_t     rd_addr;
  baddr_t     wr_addr;

  tb_clock clock_gen (.clk(clk));

  cache_top uut (.*);

  bind cache_top cache_chk u_chk (
    .clk              (clk),
    .rst              (rst),
    .br_cmd_en        (br_cmd_en),
    .br_rd_data_ready (br_rd_data_ready),
    .busy             (busy)
  );

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // expected word at a byte address from the little-endian shadow bytes
  function automatic word_t ref_word(addr_t a);
    int base;
    base = int'(a) & ~3;
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
  endfunction

  function automatic bword_t shadow_beat(baddr_t b);
    bword_t w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = shadow[8*int'(b) + i];
    end
    return w;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // burst RAM model with read data 3 cycles after the command
  always @(posedge clk) begin
    br_rd_data_ready <= 1'b0;
    if (br_cmd_en && !br_cmd) begin
      rd_addr <= br_addr;
      rd_wait <= 3;
    end else if (rd_wait > 0) begin
      rd_wait <= rd_wait - 1;
      if (rd_wait == 1) begin
        br_rd_data_ready <= 1'b1;
        br_rd_data       <= ram[rd_addr];
        rd_beat          <= 1;
      end
    end else if (rd_beat > 0) begin
      br_rd_data_ready <= 1'b1;
      br_rd_data       <= ram[rd_addr + baddr_t'(rd_beat)];
      rd_beat          <= (rd_beat == 3) ? 0 : rd_beat + 1;
    end
    if (br_cmd_en && br_cmd) begin
      evictions++;
      check("br_wr_data", br_wr_data, shadow_beat(br_addr));
      ram[br_addr] <= br_wr_data;
      wr_addr      <= br_addr;
      wr_beat      <= 1;
    end else if (wr_beat > 0) begin
      check("br_wr_data", br_wr_data, shadow_beat(wr_addr + baddr_t'(wr_beat)));
      ram[wr_addr + baddr_t'(wr_beat)] <= br_wr_data;
      wr_beat <= (wr_beat == 3) ? 0 : wr_beat + 1;
    end
  end

  // read data is checked wherever the DUT flags it valid
  always @(negedge clk) begin
    if (!rst && data_out_ready) begin
      check("data_out", data_out, ref_word(address));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: no completion within %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "run limit reached");
    end
  end

  task automatic read_word(input addr_t a, output int waits);
    @(posedge clk);
    address      <= a;
    write_enable <= '0;
    waits = 0;
    @(negedge clk);
    while (busy) begin
      waits++;
      @(negedge clk);
    end
    check("data_out_ready", data_out_ready, 1);
  endtask

  task automatic write_masked(input addr_t a, input word_t d, input wmask_t m);
    int base;
    @(posedge clk);
    address      <= a;
    data_in      <= d;
    write_enable <= m;
    @(negedge clk);
    while (busy) begin
      check("data_out_ready", data_out_ready, 0);
      @(negedge clk);
    end
    check("data_out_ready", data_out_ready, 0);
    // write lands at the next rising edge
    base = int'(a) & ~3;
    for (int i = 0; i < 4; i++) begin
      if (m[i]) begin
        shadow[base+i] = d[8*i +: 8];
      end
    end
  endtask

  initial begin
    int     waits;
    int     evict_before;
    addr_t  a;
    wmask_t m;

    rng = 32'd61;
    cycles = 0;
    evictions = 0;
    rd_wait = 0;
    rd_beat = 0;
    wr_beat = 0;
    rst = 1'b1;
    // the first request already waits while reset is held
    address = first_addr;
    data_in = '0;
    write_enable = '0;
    br_rd_data = '0;
    br_rd_data_ready = 1'b0;
    for (int i = 0; i < mem_bytes / 8; i++) begin
      ram[i] = {next_rand(), next_rand()};
      for (int j = 0; j < 8; j++) begin
        shadow[8*i + j] = ram[i][8*j +: 8];
      end
    end

    repeat (reset_len) @(posedge clk);
    rst <= 1'b0;

    // read after reset misses
    read_word(first_addr, waits);
    check("busy_on_first_read", waits != 0, 1);

    // remaining columns of the filled line hit at once
    for (int c = 1; c < 8; c++) begin
      read_word(addr_t'(first_addr + 4 * c), waits);
      check("busy", waits, 0);
    end

    write_masked(12'h128, 32'ha5a5_5a5a, 4'b0101);
    read_word(12'h128, waits);

    // another tag on the same line index evicts the dirty line
    evict_before = evictions;
    read_word(12'h320, waits);
    check("evictions", evictions - evict_before, 1);
    read_word(12'h128, waits);

    // write miss allocates the line before merging
    write_masked(12'h444, 32'h1234_5678, 4'b1110);
    read_word(12'h444, waits);

    for (int n = 0; n < num_random; n++) begin
      a = addr_t'(next_rand()) & 12'hffc;
      m = wmask_t'(next_rand());
      if (next_rand() % 2 == 0 || m == '0) begin
        read_word(a, waits);
      end else begin
        write_masked(a, next_rand(), m);
      end
    end

    @(posedge clk);
    write_enable <= '0;
    @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

/* cache_chk.sv */
/*
 * Assertions on the burst command strobe and the busy level.
 */
`timescale 1ns/1ns

module cache_chk (
  input logic clk,
  input logic rst,
  input logic br_cmd_en,
  input logic br_rd_data_ready,
  input logic busy
);

  // one command per strobe cycle
  cmd_en_single: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en
  ) else $error("br_cmd_en high on two consecutive cycles");

  // the last fill beat arrives two cycles before busy drops
  busy_after_fill: assert property (
    @(posedge clk) disable iff (rst) $fell(busy) |-> $past(br_rd_data_ready, 2)
  ) else $error("busy fell without a completed fill");

  // commands go out only while a miss is pending
  cmd_during_miss: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |-> busy
  ) else $error("br_cmd_en high while busy is low");

endmodule

/* tb_clock.sv */
/*
 * Testbench clock source, 100 ns period.
 */
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

endmodule

/* cache_top.sv */
/*
 * Direct-mapped write-back cache in front of a 64-bit burst RAM.
 * Splits the request address, forms the request-side status levels
 * and connects tag store, line store and miss controller.
 */
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_top (
  input  logic              clk,
  input  logic              rst,
  input  cache_pkg::addr_t  address,
  input  cache_pkg::word_t  data_in,
  input  cache_pkg::wmask_t write_enable,
  output cache_pkg::word_t  data_out,
  output logic              data_out_ready,
  output logic              busy,
  output logic              br_cmd,
  output logic              br_cmd_en,
  output cache_pkg::baddr_t br_addr,
  output cache_pkg::bword_t br_wr_data,
  input  cache_pkg::bword_t br_rd_data,
  input  logic              br_rd_data_ready
);
  import cache_pkg::*;

  // |tag|line|col|byte|
  col_ix_t  col_ix;
  line_ix_t line_ix;
  tag_t     req_tag;
  baddr_t   fill_baddr;
  baddr_t   victim_baddr;
  logic     hit;
  logic     dirty;
  logic     write_hit;
  logic     fill_done;

  assign col_ix     = address[`CACHE_BYTE_BITS +: `CACHE_COL_BITS];
  assign line_ix    = address[`CACHE_BYTE_BITS+`CACHE_COL_BITS +: `CACHE_LINE_IX_BITS];
  assign req_tag    = address[`CACHE_ADDR_BITS-1 -: $bits(tag_t)];
  assign fill_baddr = {req_tag, line_ix, pair_ix_t'(0)};

  assign write_hit      = (write_enable != '0) && hit;
  assign data_out_ready = (write_enable == '0) && hit;
  // a miss stays visible until the fill has written the tag
  assign busy           = !hit;

  line_fill_if fill_link ();

  cache_tag_store u_tag_store (
    .clk          (clk),
    .rst          (rst),
    .line_ix      (line_ix),
    .req_tag      (req_tag),
    .write_hit    (write_hit),
    .fill_done    (fill_done),
    .hit          (hit),
    .dirty        (dirty),
    .victim_baddr (victim_baddr)
  );

  cache_line_store u_line_store (
    .clk          (clk),
    .line_ix      (line_ix),
    .col_ix       (col_ix),
    .data_in      (data_in),
    .write_enable (write_enable),
    .write_hit    (write_hit),
    .data_out     (data_out),
    .fill         (fill_link.store)
  );

  cache_miss_ctrl u_miss_ctrl (
    .clk              (clk),
    .rst              (rst),
    .hit              (hit),
    .dirty            (dirty),
    .victim_baddr     (victim_baddr),
    .fill_baddr       (fill_baddr),
    .fill_done        (fill_done),
    .fill             (fill_link.ctrl),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_ready (br_rd_data_ready)
  );

endmodule

/* cache_miss_ctrl.sv */
/*
 * Miss controller FSM. Writes a dirty victim line back as a four-beat
 * burst, then reads the requested line in a four-beat burst and hands
 * each beat to the line store, finishing with the tag update.
 */
`timescale 1ns/1ns

module cache_miss_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              hit,
  input  logic              dirty,
  input  cache_pkg::baddr_t victim_baddr,
  input  cache_pkg::baddr_t fill_baddr,
  output logic              fill_done,
  line_fill_if.ctrl         fill,
  output logic              br_cmd,
  output logic              br_cmd_en,
  output cache_pkg::baddr_t br_addr,
  output cache_pkg::bword_t br_wr_data,
  input  cache_pkg::bword_t br_rd_data,
  input  logic              br_rd_data_ready
);
  import cache_pkg::*;

  miss_state_t state;

  // beat within the line, zero whenever the FSM is idle
  pair_ix_t    beat;

  assign fill.evict_pair = beat;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= miss_idle;
      beat          <= '0;
      br_cmd        <= 1'b0;
      br_cmd_en     <= 1'b0;
      fill.fill_en  <= 1'b0;
      fill_done     <= 1'b0;
    end else begin
      // command strobe lasts one cycle
      br_cmd_en <= 1'b0;

      unique case (state)
        miss_idle: begin
          if (!hit) begin
            br_cmd_en <= 1'b1;
            if (dirty) begin
              // write command goes out together with beat 0
              br_cmd     <= 1'b1;
              br_addr    <= victim_baddr;
              br_wr_data <= fill.evict_data;
              beat       <= beat + 1'b1;
              state      <= miss_evict;
            end else begin
              br_cmd  <= 1'b0;
              br_addr <= fill_baddr;
              state   <= miss_fill_wait;
            end
          end
        end

        miss_evict: begin
          if (beat == '0) begin
            // last beat is on the bus, issue the line read next
            br_cmd    <= 1'b0;
            br_cmd_en <= 1'b1;
            br_addr   <= fill_baddr;
            state     <= miss_fill_wait;
          end else begin
            br_wr_data <= fill.evict_data;
            beat       <= beat + 1'b1;
          end
        end

        miss_fill_wait, miss_fill: begin
          // beats 1 to 3 follow beat 0 back to back
          if (state == miss_fill || br_rd_data_ready) begin
            fill.fill_en   <= 1'b1;
            fill.fill_pair <= beat;
            fill.fill_data <= br_rd_data;
            beat           <= beat + 1'b1;
            state          <= miss_fill;
            if (beat == pair_ix_t'(3)) begin
              fill_done <= 1'b1;
              state     <= miss_finish;
            end
          end
        end

        miss_finish: begin
          // last pair and the tag are written at the end of this cycle
          fill.fill_en <= 1'b0;
          fill_done    <= 1'b0;
          state        <= miss_idle;
        end

        default: begin
          state <= miss_idle;
        end
      endcase
    end
  end

endmodule

/* cache_line_store.sv */
/*
 * Cache data array of 16 lines by 8 columns. Byte-masked writes from
 * the requester, column pair writes from a fill, and combinational
 * reads of one column and of one column pair.
 */
`timescale 1ns/1ns

module cache_line_store (
  input  logic               clk,
  input  cache_pkg::line_ix_t line_ix,
  input  cache_pkg::col_ix_t col_ix,
  input  cache_pkg::word_t   data_in,
  input  cache_pkg::wmask_t  write_enable,
  input  logic               write_hit,
  output cache_pkg::word_t   data_out,
  line_fill_if.store         fill
);
  import cache_pkg::*;

  localparam int num_lines = 2 ** $bits(line_ix_t);
  localparam int num_cols  = 2 ** $bits(col_ix_t);
  localparam int num_bytes = $bits(wmask_t);

  word_t   mem [num_lines][num_cols];

  col_ix_t fill_col_lo;
  col_ix_t fill_col_hi;
  col_ix_t evict_col_lo;
  col_ix_t evict_col_hi;

  // the low column of a pair sits in bits 31:0 of the burst word
  assign fill_col_lo  = {fill.fill_pair, 1'b0};
  assign fill_col_hi  = {fill.fill_pair, 1'b1};
  assign evict_col_lo = {fill.evict_pair, 1'b0};
  assign evict_col_hi = {fill.evict_pair, 1'b1};

  always_ff @(posedge clk) begin
    if (fill.fill_en) begin
      mem[line_ix][fill_col_lo] <= fill.fill_data[31:0];
      mem[line_ix][fill_col_hi] <= fill.fill_data[63:32];
    end else if (write_hit) begin
      for (int b = 0; b < num_bytes; b++) begin
        if (write_enable[b]) begin
          mem[line_ix][col_ix][8*b +: 8] <= data_in[8*b +: 8];
        end
      end
    end
  end

  assign data_out = mem[line_ix][col_ix];

  // pair read for the eviction burst
  assign fill.evict_data = {mem[line_ix][evict_col_hi], mem[line_ix][evict_col_lo]};

endmodule

/* cache_tag_store.sv */
/*
 * Tag, valid and dirty bits per line, with the hit and dirty lookup
 * for the addressed line and the burst address of its current occupant.
 */
`timescale 1ns/1ns

module cache_tag_store (
  input  logic                clk,
  input  logic                rst,
  input  cache_pkg::line_ix_t line_ix,
  input  cache_pkg::tag_t     req_tag,
  input  logic                write_hit,
  input  logic                fill_done,
  output logic                hit,
  output logic                dirty,
  output cache_pkg::baddr_t   victim_baddr
);
  import cache_pkg::*;

  localparam int num_lines = 2 ** $bits(line_ix_t);

  tag_t                 tag_mem [num_lines];
  logic [num_lines-1:0] line_valid;
  logic [num_lines-1:0] line_dirty;

  always_ff @(posedge clk) begin
    if (fill_done) begin
      tag_mem[line_ix] <= req_tag;
    end
  end

  // a completed fill always leaves the line clean
  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
      line_dirty <= '0;
    end else if (fill_done) begin
      line_valid[line_ix] <= 1'b1;
      line_dirty[line_ix] <= 1'b0;
    end else if (write_hit) begin
      line_dirty[line_ix] <= 1'b1;
    end
  end

  assign hit   = line_valid[line_ix] && (tag_mem[line_ix] == req_tag);
  assign dirty = line_valid[line_ix] && line_dirty[line_ix];

  // base burst word of the resident line, four burst words per line
  assign victim_baddr = {tag_mem[line_ix], line_ix, pair_ix_t'(0)};

endmodule

/* line_fill_if.sv */
/*
 * Beat-level link between the miss controller and the line store:
 * fill writes of a column pair and eviction reads of a column pair.
 */
`timescale 1ns/1ns

interface line_fill_if;
  import cache_pkg::*;

  logic     fill_en;
  pair_ix_t fill_pair;
  bword_t   fill_data;
  pair_ix_t evict_pair;
  // combinational, follows evict_pair in the same cycle
  bword_t   evict_data;

  modport ctrl (
    output fill_en, fill_pair, fill_data, evict_pair,
    input  evict_data
  );

  modport store (
    input  fill_en, fill_pair, fill_data, evict_pair,
    output evict_data
  );

endinterface

/* cache_pkg.sv */
/*
 * Cache types: address fields, data and burst words, and the miss
 * controller state encoding.
 */
`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_BITS-1:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] wmask_t;
  typedef logic [`CACHE_LINE_IX_BITS-1:0] line_ix_t;
  typedef logic [`CACHE_COL_BITS-1:0] col_ix_t;
  typedef logic [`CACHE_ADDR_BITS-`CACHE_LINE_IX_BITS-`CACHE_COL_BITS-`CACHE_BYTE_BITS-1:0] tag_t;

  // burst RAM side, one 64-bit word holds a pair of columns
  typedef logic [63:0] bword_t;
  typedef logic [`CACHE_ADDR_BITS-`CACHE_BYTE_BITS-2:0] baddr_t;
  typedef logic [`CACHE_COL_BITS-2:0] pair_ix_t;

  typedef enum logic [2:0] {
    miss_idle,
    miss_evict,
    miss_fill_wait,
    miss_fill,
    miss_finish
  } miss_state_t;

endpackage

/* cache_cfg.svh */
/*
 * Cache geometry macros: byte address width and the widths of the line
 * index, column index and byte offset fields.
 */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address width, covers 4 KiB of burst RAM
`define CACHE_ADDR_BITS 12

// 16 lines in the cache
`define CACHE_LINE_IX_BITS 4

// 8 columns of 32 bits per line
`define CACHE_COL_BITS 3

// byte offset inside a 32-bit column
`define CACHE_BYTE_BITS 2

`endif
